// ==== rtl/edge_pkg.sv ====
package edge_pkg;

	////////////////////////////////////////////////////////////
	// sizes
	////////////////////////////////////////////////////////////
	localparam int word_bits     = 32;
	localparam int line_words    = 8;
	localparam int line_bits     = word_bits * line_words; // 256
	localparam int addr_bits     = 32;
	localparam int count_bits    = 16;
	localparam int apb_addr_bits = 8;

	// which inverse edge array a read belongs to
	typedef enum logic [1:0] {
		array_src    = 2'd0,
		array_dest   = 2'd1,
		array_weight = 2'd2
	} edge_array_t;

	////////////////////////////////////////////////////////////
	// register map
	////////////////////////////////////////////////////////////
	localparam logic [apb_addr_bits-1:0] reg_ctrl        = 8'h00; // bit 0 enable
	localparam logic [apb_addr_bits-1:0] reg_src_base    = 8'h04;
	localparam logic [apb_addr_bits-1:0] reg_dest_base   = 8'h08;
	localparam logic [apb_addr_bits-1:0] reg_weight_base = 8'h0C;
	localparam logic [apb_addr_bits-1:0] reg_edge_count  = 8'h10; // read only

	////////////////////////////////////////////////////////////
	// shared structs
	////////////////////////////////////////////////////////////
	typedef struct packed {
		logic                  valid;
		logic [count_bits-1:0] edge_idx;   // first edge of the vertex
		logic [count_bits-1:0] edge_count;
	} vertex_job_t;

	typedef struct packed {
		edge_array_t array;
		logic [2:0]  shift;       // word offset of first wanted word
		logic [3:0]  real_count;  // 1 to 8 words used
	} read_tag_t;

	typedef struct packed {
		logic                 valid;
		logic [3:0]           unit_id;
		logic [addr_bits-1:0] address; // line aligned
		read_tag_t            tag;
	} read_cmd_t;

	typedef struct packed {
		logic                 valid;
		read_tag_t            tag;
		logic [line_bits-1:0] data;
	} read_resp_t;

	typedef struct packed {
		logic                  valid;
		logic [count_bits-1:0] id;
		logic [word_bits-1:0]  src;
		logic [word_bits-1:0]  dest;
		logic [word_bits-1:0]  weight;
	} edge_t;

	typedef struct packed {
		logic                 enable;
		logic [addr_bits-1:0] src_base;
		logic [addr_bits-1:0] dest_base;
		logic [addr_bits-1:0] weight_base;
	} edge_cfg_t;

endpackage

// ==== rtl/edge_cfg_regs.sv ====
`timescale 1ns/1ns

module edge_cfg_regs (
	input  logic                               clock,
	input  logic                               rstn,
	input  logic                               psel,
	input  logic                               penable,
	input  logic                               pwrite,
	input  logic [edge_pkg::apb_addr_bits-1:0] paddr,
	input  logic [31:0]                        pwdata,
	output logic [31:0]                        prdata,
	output logic                               pready,
	output logic                               pslverr,
	input  logic                               edge_pop,
	output edge_pkg::edge_cfg_t                cfg
);

	logic        access;     // apb access phase
	logic        mapped;
	logic        wr_ok;
	logic [31:0] edge_count; // edges delivered to the consumer

	assign access = psel & penable;
	assign pready = 1'b1; // no wait states

	// read mux and address decode
	always_comb begin
		mapped = 1'b1;
		prdata = '0;
		case (paddr)
			edge_pkg::reg_ctrl:        prdata = {31'b0, cfg.enable};
			edge_pkg::reg_src_base:    prdata = cfg.src_base;
			edge_pkg::reg_dest_base:   prdata = cfg.dest_base;
			edge_pkg::reg_weight_base: prdata = cfg.weight_base;
			edge_pkg::reg_edge_count:  prdata = edge_count;
			default:                   mapped = 1'b0;
		endcase
	end

	// counter is read only
	assign pslverr = access & (~mapped | (pwrite & (paddr == edge_pkg::reg_edge_count)));
	assign wr_ok   = access & pwrite & ~pslverr;

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			cfg <= '0;
		end else if (wr_ok) begin
			case (paddr)
				edge_pkg::reg_ctrl:        cfg.enable      <= pwdata[0];
				edge_pkg::reg_src_base:    cfg.src_base    <= pwdata;
				edge_pkg::reg_dest_base:   cfg.dest_base   <= pwdata;
				edge_pkg::reg_weight_base: cfg.weight_base <= pwdata;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn)
			edge_count <= '0;
		else if (edge_pop)
			edge_count <= edge_count + 32'd1;
	end

endmodule

// ==== rtl/edge_job_control.sv ====
`timescale 1ns/1ns

module edge_job_control #(
	parameter logic [3:0] unit_id    = 4'd1,
	parameter int         fifo_depth = 16
) (
	input  logic                                 clock,
	input  logic                                 rstn,
	input  edge_pkg::edge_cfg_t                  cfg,
	input  edge_pkg::vertex_job_t                vertex_job,
	output logic                                 vertex_ready,
	output edge_pkg::read_cmd_t                  read_cmd,
	input  logic                                 read_cmd_ready,
	input  logic                                 read_resp_valid,
	input  logic [2:0]                           lines_ready,
	input  logic                                 fifo_alfull,
	output logic                                 fill,
	output logic [2:0]                           cur_shift,
	output logic [3:0]                           cur_count,  // edges left in chunk
	output logic [edge_pkg::count_bits-1:0]      cur_first   // id of the next edge
);

	// a chunk never holds more than the fifo can take
	localparam int max_chunk = (fifo_depth < edge_pkg::line_words) ?
		fifo_depth : edge_pkg::line_words;

	typedef enum logic [2:0] {
		st_idle, st_init, st_calc, st_send_src, st_send_dest, st_send_weight, st_wait
	} state_t;

	state_t                          state, next_state;
	edge_pkg::vertex_job_t           job_q;
	logic [edge_pkg::count_bits-1:0] remaining;   // edges not yet in a chunk
	logic [1:0]                      outstanding; // reads in flight
	logic [3:0]                      room;
	logic [3:0]                      chunk_len;
	logic                            cmd_accept;
	logic [edge_pkg::addr_bits-1:0]  base_addr;
	logic [edge_pkg::addr_bits-1:0]  byte_off;
	logic [edge_pkg::addr_bits-1:0]  line_addr;

	assign vertex_ready = (state == st_idle) & cfg.enable;
	assign cmd_accept   = read_cmd.valid & read_cmd_ready;
	assign fill = (state == st_wait) & (&lines_ready) & (outstanding == 2'd0);

	////////////////////////////////////////////////////////////
	// chunk rule
	////////////////////////////////////////////////////////////
	always_comb begin
		room = 4'(edge_pkg::line_words) - {1'b0, cur_first[2:0]};
		if (room > 4'(max_chunk))
			room = 4'(max_chunk);
		chunk_len = (remaining < 16'(room)) ? remaining[3:0] : room;
	end

	////////////////////////////////////////////////////////////
	// fsm
	////////////////////////////////////////////////////////////
	always_comb begin
		next_state = state;
		case (state)
			st_idle:        if (vertex_ready & vertex_job.valid) next_state = st_init;
			st_init: begin
				if (job_q.edge_count == '0)
					next_state = st_idle; // nothing to fetch
				else if (~fifo_alfull)
					next_state = st_calc;
			end
			st_calc:        next_state = st_send_src;
			st_send_src:    if (read_cmd_ready) next_state = st_send_dest;
			st_send_dest:   if (read_cmd_ready) next_state = st_send_weight;
			st_send_weight: if (read_cmd_ready) next_state = st_wait;
			st_wait: begin
				// chunk fully pushed, look at the next one
				if (cur_count == 4'd0 && outstanding == 2'd0) begin
					if (remaining == '0)
						next_state = st_idle;
					else if (~fifo_alfull)
						next_state = st_calc;
				end
			end
			default:        next_state = st_idle;
		endcase
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			state     <= st_idle;
			job_q     <= '0;
			remaining <= '0;
			cur_first <= '0;
			cur_shift <= '0;
			cur_count <= '0;
		end else begin
			state <= next_state;
			case (state)
				st_idle: if (vertex_ready & vertex_job.valid) job_q <= vertex_job;
				st_init: begin
					cur_first <= job_q.edge_idx;
					remaining <= job_q.edge_count;
				end
				st_calc: begin
					cur_shift <= cur_first[2:0];
					cur_count <= chunk_len;
					remaining <= remaining - 16'(chunk_len);
				end
				st_wait: begin
					if (fill && cur_count != 4'd0) begin
						cur_count <= cur_count - 4'd1;
						cur_first <= cur_first + 16'd1; // next chunk starts here
					end
				end
				default: ;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// read command and response tracking
	////////////////////////////////////////////////////////////
	always_comb begin
		read_cmd = '0;
		case (state)
			st_send_dest:   base_addr = cfg.dest_base;
			st_send_weight: base_addr = cfg.weight_base;
			default:        base_addr = cfg.src_base;
		endcase
		byte_off = '0;
		byte_off[edge_pkg::count_bits+1:0] = {cur_first, 2'b00}; // 4 bytes per edge
		line_addr = base_addr + byte_off;
		read_cmd.valid   = (state == st_send_src) | (state == st_send_dest) |
			(state == st_send_weight);
		read_cmd.unit_id = unit_id;
		read_cmd.address = {line_addr[edge_pkg::addr_bits-1:5], 5'b0};
		case (state)
			st_send_dest:   read_cmd.tag.array = edge_pkg::array_dest;
			st_send_weight: read_cmd.tag.array = edge_pkg::array_weight;
			default:        read_cmd.tag.array = edge_pkg::array_src;
		endcase
		read_cmd.tag.shift      = cur_shift;
		read_cmd.tag.real_count = cur_count;
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn)
			outstanding <= '0;
		else if (cmd_accept & ~read_resp_valid)
			outstanding <= outstanding + 2'd1;
		else if (read_resp_valid & ~cmd_accept)
			outstanding <= outstanding - 2'd1;
	end

endmodule

// ==== rtl/cacheline_stream.sv ====
`timescale 1ns/1ns

module cacheline_stream #(
	parameter edge_pkg::edge_array_t array_sel = edge_pkg::array_src
) (
	input  logic                             clock,
	input  logic                             rstn,
	input  edge_pkg::read_resp_t             read_resp,
	input  logic [2:0]                       shift,
	input  logic                             fill,
	output logic [edge_pkg::word_bits-1:0]   word,
	output logic                             line_ready
);

	logic [edge_pkg::line_bits-1:0] line;
	logic [3:0]                     fills_left;
	logic                           capture;
	logic                           advance;

	assign capture = read_resp.valid & (read_resp.tag.array == array_sel);
	assign advance = fill & line_ready;
	assign word    = line[edge_pkg::word_bits-1:0]; // lowest word goes out first

	// line data, dropping the words before the first wanted edge
	always_ff @(posedge clock) begin
		if (capture)
			line <= read_resp.data >> {shift, 5'b0};
		else if (advance)
			line <= line >> edge_pkg::word_bits;
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			line_ready <= 1'b0;
			fills_left <= '0;
		end else if (capture) begin
			line_ready <= 1'b1;
			fills_left <= read_resp.tag.real_count;
		end else if (advance) begin
			fills_left <= fills_left - 4'd1;
			if (fills_left == 4'd1)
				line_ready <= 1'b0; // last word of the chunk
		end
	end

endmodule

// ==== rtl/edge_fifo.sv ====
`timescale 1ns/1ns

module edge_fifo #(
	parameter int depth = 16
) (
	input  logic            clock,
	input  logic            rstn,
	input  logic            push,
	input  edge_pkg::edge_t data_in,
	input  logic            pop,
	output edge_pkg::edge_t data_out,
	output logic            full,
	output logic            alfull
);

	localparam int ptr_bits = $clog2(depth);

	edge_pkg::edge_t     mem [depth];
	logic [ptr_bits-1:0] wr_ptr;
	logic [ptr_bits-1:0] rd_ptr;
	logic [ptr_bits:0]   count;
	logic                do_push;
	logic                do_pop;

	assign do_push = push & ~full;
	assign do_pop  = pop & (count != '0);
	assign full    = (int'(count) == depth);
	assign alfull  = (depth - int'(count)) < edge_pkg::line_words; // no room for a chunk

	// head entry shown directly
	always_comb begin
		data_out       = mem[rd_ptr];
		data_out.valid = (count != '0);
	end

	always_ff @(posedge clock) begin
		if (do_push)
			mem[wr_ptr] <= data_in;
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == ptr_bits'(depth - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == ptr_bits'(depth - 1)) ? '0 : rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: ;
			endcase
		end
	end

endmodule

// ==== rtl/edge_fetch_top.sv ====
`timescale 1ns/1ns

module edge_fetch_top #(
	parameter logic [3:0] unit_id    = 4'd1,
	parameter int         fifo_depth = 16
) (
	input  logic                               clock,
	input  logic                               rstn,
	input  logic                               psel,
	input  logic                               penable,
	input  logic                               pwrite,
	input  logic [edge_pkg::apb_addr_bits-1:0] paddr,
	input  logic [31:0]                        pwdata,
	output logic [31:0]                        prdata,
	output logic                               pready,
	output logic                               pslverr,
	input  edge_pkg::vertex_job_t              vertex_job,
	output logic                               vertex_ready,
	output edge_pkg::read_cmd_t                read_cmd,
	input  logic                               read_cmd_ready,
	input  edge_pkg::read_resp_t               read_resp,
	output edge_pkg::edge_t                    edge_out,
	input  logic                               edge_ready
);

	edge_pkg::edge_cfg_t             cfg;
	edge_pkg::edge_t                 edge_in;
	logic                            edge_pop;
	logic                            fill;
	logic                            push;
	logic [2:0]                      lines_ready; // {weight, dest, src}
	logic [2:0]                      cur_shift;
	logic [3:0]                      cur_count;
	logic [edge_pkg::count_bits-1:0] cur_first;
	logic [edge_pkg::word_bits-1:0]  src_word;
	logic [edge_pkg::word_bits-1:0]  dest_word;
	logic [edge_pkg::word_bits-1:0]  weight_word;
	logic                            fifo_full;
	logic                            fifo_alfull;

	assign edge_pop = edge_out.valid & edge_ready;
	assign push     = fill & (cur_count != 4'd0) & ~fifo_full; // one edge per fill

	always_comb begin
		edge_in.valid  = push;
		edge_in.id     = cur_first;
		edge_in.src    = src_word;
		edge_in.dest   = dest_word;
		edge_in.weight = weight_word;
	end

	edge_cfg_regs i_edge_cfg_regs (
		.clock(clock), .rstn(rstn),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.edge_pop(edge_pop), .cfg(cfg)
	);

	edge_job_control #(.unit_id(unit_id), .fifo_depth(fifo_depth)) i_edge_job_control (
		.clock(clock), .rstn(rstn), .cfg(cfg),
		.vertex_job(vertex_job), .vertex_ready(vertex_ready),
		.read_cmd(read_cmd), .read_cmd_ready(read_cmd_ready),
		.read_resp_valid(read_resp.valid), .lines_ready(lines_ready),
		.fifo_alfull(fifo_alfull), .fill(fill),
		.cur_shift(cur_shift), .cur_count(cur_count), .cur_first(cur_first)
	);

	////////////////////////////////////////////////////////////
	// one stream per inverse edge array
	////////////////////////////////////////////////////////////
	cacheline_stream #(.array_sel(edge_pkg::array_src)) i_stream_src (
		.clock(clock), .rstn(rstn), .read_resp(read_resp), .shift(cur_shift),
		.fill(push), .word(src_word), .line_ready(lines_ready[0])
	);

	cacheline_stream #(.array_sel(edge_pkg::array_dest)) i_stream_dest (
		.clock(clock), .rstn(rstn), .read_resp(read_resp), .shift(cur_shift),
		.fill(push), .word(dest_word), .line_ready(lines_ready[1])
	);

	cacheline_stream #(.array_sel(edge_pkg::array_weight)) i_stream_weight (
		.clock(clock), .rstn(rstn), .read_resp(read_resp), .shift(cur_shift),
		.fill(push), .word(weight_word), .line_ready(lines_ready[2])
	);

	edge_fifo #(.depth(fifo_depth)) i_edge_fifo (
		.clock(clock), .rstn(rstn),
		.push(push), .data_in(edge_in),
		.pop(edge_pop), .data_out(edge_out),
		.full(fifo_full), .alfull(fifo_alfull)
	);

endmodule

// ==== sim/tb_edge_fetch.sv ====
`timescale 1ns/1ns

module tb_edge_fetch;

	localparam int         fifo_depth = 16;
	localparam logic [3:0] unit_id    = 4'd3;
	localparam int         max_items  = 128;

	logic                               clock;
	logic                               rstn;
	logic                               psel;
	logic                               penable;
	logic                               pwrite;
	logic [edge_pkg::apb_addr_bits-1:0] paddr;
	logic [31:0]                        pwdata;
	logic [31:0]                        prdata;
	logic                               pready;
	logic                               pslverr;
	edge_pkg::vertex_job_t              vertex_job;
	logic                               vertex_ready;
	edge_pkg::read_cmd_t                read_cmd;
	logic                               read_cmd_ready;
	edge_pkg::read_resp_t               read_resp;
	edge_pkg::edge_t                    edge_out;
	logic                               edge_ready;

	// expected streams, filled by the job model
	edge_pkg::read_cmd_t exp_cmds [max_items];
	edge_pkg::edge_t     exp_edges [max_items];
	edge_pkg::read_cmd_t exp_cmd;
	edge_pkg::edge_t     exp_edge;
	int                  cmd_rd;
	int                  cmd_wr;
	int                  edge_rd;       // also the popped count
	int                  edge_wr;
	int                  issued_edges;  // edges asked of memory so far
	logic [31:0]         bases [3];
	logic [31:0]         exp_rdata;
	logic                exp_err;
	logic                enable_model;
	logic                shuffle;       // late, out of order responses
	logic                backpressure;
	logic [31:0]         rng_mem;
	logic [31:0]         rng_cons;
	int                  stretch;
	edge_pkg::read_cmd_t pend_cmd [$];
	int                  pend_wait [$];
	int                  reg_errors;
	int                  cmd_errors;
	int                  edge_errors;
	int                  flow_errors;
	int                  timeouts;
	logic                cmd_accept;
	logic                edge_pop;

	assign cmd_accept = read_cmd.valid & read_cmd_ready;
	assign edge_pop   = edge_out.valid & edge_ready;
	assign exp_cmd    = exp_cmds[cmd_rd];
	assign exp_edge   = exp_edges[edge_rd];

	edge_fetch_top #(.unit_id(unit_id), .fifo_depth(fifo_depth)) i_edge_fetch_top (.*);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] mem_word(input logic [31:0] addr);
		return addr ^ 32'hA5A5_0000;
	endfunction

	function automatic edge_pkg::read_resp_t make_resp(input edge_pkg::read_cmd_t cmd);
		edge_pkg::read_resp_t r;
		int                   i;
		r.valid = 1'b1;
		r.tag   = cmd.tag;
		for (i = 0; i < edge_pkg::line_words; i++)
			r.data[32*i +: 32] = mem_word(cmd.address + 32'(4 * i));
		return r;
	endfunction

	////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////
	assert property (@(posedge clock) !rstn |-> !read_cmd.valid && !edge_out.valid && !vertex_ready)
		else begin
			flow_errors++;
			$display("outputs active during reset");
		end
	assert property (@(posedge clock) disable iff (!rstn) psel && penable |-> pready)
		else begin
			reg_errors++;
			$display("[FAIL] pready got 0x%h expected 0x1", $sampled(pready));
		end
	assert property (@(posedge clock) disable iff (!rstn) psel && penable |-> pslverr == exp_err)
		else begin
			reg_errors++;
			$display("[FAIL] pslverr got 0x%h expected 0x%h", $sampled(pslverr), $sampled(exp_err));
		end
	assert property (@(posedge clock) disable iff (!rstn)
		psel && penable && !pwrite && !exp_err |-> prdata == exp_rdata)
		else begin
			reg_errors++;
			$display("[FAIL] prdata got 0x%h expected 0x%h", $sampled(prdata), $sampled(exp_rdata));
		end
	assert property (@(posedge clock) disable iff (!rstn) cmd_accept |-> cmd_rd < cmd_wr)
		else begin
			flow_errors++;
			$display("read command accepted that no job asked for");
		end
	assert property (@(posedge clock) disable iff (!rstn)
		cmd_accept && cmd_rd < cmd_wr |-> read_cmd.address == exp_cmd.address)
		else begin
			cmd_errors++;
			$display("[FAIL] read_cmd.address got 0x%h expected 0x%h",
				$sampled(read_cmd.address), $sampled(exp_cmd.address));
		end
	assert property (@(posedge clock) disable iff (!rstn) cmd_accept && cmd_rd < cmd_wr |->
		read_cmd.tag == exp_cmd.tag && read_cmd.unit_id == exp_cmd.unit_id)
		else begin
			cmd_errors++;
			$display("[FAIL] read_cmd tag,unit got 0x%h,0x%h expected 0x%h,0x%h",
				$sampled(read_cmd.tag), $sampled(read_cmd.unit_id),
				$sampled(exp_cmd.tag), $sampled(exp_cmd.unit_id));
		end
	// a chunk only starts with room for a whole line
	assert property (@(posedge clock) disable iff (!rstn)
		cmd_accept && read_cmd.tag.array == edge_pkg::array_src |->
		issued_edges - edge_rd <= fifo_depth - edge_pkg::line_words)
		else begin
			flow_errors++;
			$display("read command sent while the FIFO was almost full");
		end
	assert property (@(posedge clock) disable iff (!rstn) !enable_model |->
		!vertex_ready && !read_cmd.valid)
		else begin
			flow_errors++;
			$display("unit active while disabled");
		end
	assert property (@(posedge clock) disable iff (!rstn) edge_pop |-> edge_rd < edge_wr)
		else begin
			flow_errors++;
			$display("edge popped beyond the expected stream");
		end
	assert property (@(posedge clock) disable iff (!rstn)
		edge_pop && edge_rd < edge_wr |-> edge_out.id == exp_edge.id)
		else begin
			edge_errors++;
			$display("[FAIL] edge_out.id got 0x%h expected 0x%h",
				$sampled(edge_out.id), $sampled(exp_edge.id));
		end
	assert property (@(posedge clock) disable iff (!rstn) edge_pop && edge_rd < edge_wr |->
		{edge_out.src, edge_out.dest, edge_out.weight} ==
		{exp_edge.src, exp_edge.dest, exp_edge.weight})
		else begin
			edge_errors++;
			$display("[FAIL] edge_out.src,dest,weight got 0x%h expected 0x%h",
				$sampled({edge_out.src, edge_out.dest, edge_out.weight}),
				$sampled({exp_edge.src, exp_edge.dest, exp_edge.weight}));
		end

	always @(posedge clock) begin : track_progress
		if (rstn) begin
			if (cmd_accept) begin
				cmd_rd <= cmd_rd + 1;
				if (read_cmd.tag.array == edge_pkg::array_src)
					issued_edges <= issued_edges + int'(read_cmd.tag.real_count);
			end
			if (edge_pop)
				edge_rd <= edge_rd + 1;
		end
	end

	////////////////////////////////////////////////////////////
	// memory and consumer models
	////////////////////////////////////////////////////////////
	always @(posedge clock) begin : memory_model
		int i;
		int pick;
		read_resp <= '0; // one beat per response
		rng_mem = xorshift32(rng_mem);
		read_cmd_ready <= shuffle ? ((rng_mem & 32'h3) != 0) : 1'b1;
		for (i = 0; i < pend_wait.size(); i++)
			if (pend_wait[i] > 0)
				pend_wait[i]--;
		pick = -1;
		if (pend_cmd.size() > 0) begin
			rng_mem = xorshift32(rng_mem);
			i = shuffle ? int'(rng_mem % pend_cmd.size()) : 0;
			if (pend_wait[i] == 0)
				pick = i;
		end
		if (pick >= 0) begin
			read_resp <= make_resp(pend_cmd[pick]);
			pend_cmd.delete(pick);
			pend_wait.delete(pick);
		end
		if (rstn && cmd_accept) begin
			rng_mem = xorshift32(rng_mem);
			pend_cmd.push_back(read_cmd);
			pend_wait.push_back(shuffle ? int'(1 + rng_mem % 12) : 0);
		end
	end

	always @(posedge clock) begin : consumer
		if (!backpressure) begin
			edge_ready <= 1'b1;
		end else if (stretch == 0) begin
			rng_cons = xorshift32(rng_cons);
			edge_ready <= ~edge_ready;
			stretch = int'(rng_cons % 10); // random stretch length
		end else begin
			stretch--;
		end
	end

	////////////////////////////////////////////////////////////
	// stimulus tasks
	////////////////////////////////////////////////////////////
	task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
		input logic [31:0] rdata_exp, input logic err_exp);
		int t;
		@(posedge clock);
		psel      <= 1'b1;
		penable   <= 1'b0;
		pwrite    <= wr;
		paddr     <= addr;
		pwdata    <= wdata;
		exp_rdata <= rdata_exp;
		exp_err   <= err_exp;
		@(posedge clock);
		penable <= 1'b1;
		for (t = 0; t < 20; t++) begin
			@(posedge clock);
			if (pready)
				break;
		end
		if (t == 20) begin
			timeouts++;
			$display("timeout waiting for pready");
		end
		if (wr && !err_exp && addr == edge_pkg::reg_ctrl)
			enable_model <= wdata[0];
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	// expected commands and edges from the chunk rule
	task automatic plan_job(input int first, input int count);
		int idx;
		int left;
		int shift;
		int n;
		int a;
		int k;
		idx  = first;
		left = count;
		while (left > 0) begin
			shift = idx % edge_pkg::line_words;
			n     = (left < 8 - shift) ? left : 8 - shift;
			for (a = 0; a < 3; a++) begin
				exp_cmds[cmd_wr].valid   = 1'b1;
				exp_cmds[cmd_wr].unit_id = unit_id;
				exp_cmds[cmd_wr].address = (bases[a] + 32'(4 * idx)) & ~32'h1f;
				exp_cmds[cmd_wr].tag     = '{edge_pkg::edge_array_t'(a), 3'(shift), 4'(n)};
				cmd_wr++;
			end
			for (k = 0; k < n; k++) begin
				exp_edges[edge_wr].valid  = 1'b1;
				exp_edges[edge_wr].id     = 16'(idx + k);
				exp_edges[edge_wr].src    = mem_word(bases[0] + 32'(4 * (idx + k)));
				exp_edges[edge_wr].dest   = mem_word(bases[1] + 32'(4 * (idx + k)));
				exp_edges[edge_wr].weight = mem_word(bases[2] + 32'(4 * (idx + k)));
				edge_wr++;
			end
			idx  += n;
			left -= n;
		end
	endtask

	task automatic drive_job(input int first, input int count);
		plan_job(first, count);
		@(posedge clock);
		vertex_job <= '{1'b1, 16'(first), 16'(count)};
	endtask

	task automatic wait_job_accept();
		int t;
		for (t = 0; t < 200; t++) begin
			@(posedge clock);
			if (vertex_ready && vertex_job.valid)
				break;
		end
		vertex_job <= '0;
		if (t == 200) begin
			timeouts++;
			$display("timeout waiting for the vertex job handshake");
		end
	endtask

	task automatic wait_job_done();
		int t;
		for (t = 0; t < 3000 && edge_rd != edge_wr; t++)
			@(posedge clock);
		if (t == 3000) begin
			timeouts++;
			$display("timeout waiting for the edge stream to drain");
		end
		for (t = 0; t < 100 && !vertex_ready; t++)
			@(posedge clock);
		if (t == 100) begin
			timeouts++;
			$display("timeout waiting for the unit to go idle");
		end
	endtask

	task automatic run_job(input int first, input int count);
		drive_job(first, count);
		wait_job_accept();
		wait_job_done();
	endtask

	initial begin : main
		rstn           = 1'b0;
		psel           = 1'b0;
		penable        = 1'b0;
		pwrite         = 1'b0;
		paddr          = '0;
		pwdata         = '0;
		vertex_job     = '0;
		read_cmd_ready = 1'b0;
		read_resp      = '0;
		edge_ready     = 1'b0;
		{cmd_rd, cmd_wr, edge_rd, edge_wr, issued_edges, stretch} = '0;
		{reg_errors, cmd_errors, edge_errors, flow_errors, timeouts} = '0;
		{exp_err, enable_model, shuffle, backpressure} = '0;
		exp_rdata = '0;
		rng_mem   = 32'd80256;
		rng_cons  = xorshift32(32'd80256);
		bases     = '{32'h0001_0000, 32'h0002_0400, 32'h0003_8000};
		repeat (4) @(posedge clock);
		rstn <= 1'b1;

		// register access
		apb_access(1, edge_pkg::reg_src_base, bases[0], 0, 0);
		apb_access(1, edge_pkg::reg_dest_base, bases[1], 0, 0);
		apb_access(1, edge_pkg::reg_weight_base, bases[2], 0, 0);
		apb_access(1, edge_pkg::reg_ctrl, 32'h1, 0, 0);
		apb_access(0, edge_pkg::reg_src_base, 0, bases[0], 0);
		apb_access(0, edge_pkg::reg_dest_base, 0, bases[1], 0);
		apb_access(0, edge_pkg::reg_weight_base, 0, bases[2], 0);
		apb_access(0, edge_pkg::reg_ctrl, 0, 32'h1, 0);
		apb_access(0, 8'h20, 0, 0, 1);
		apb_access(1, 8'h14, 32'h5, 0, 1);
		apb_access(1, edge_pkg::reg_edge_count, 32'h7, 0, 1);

		// aligned then misaligned, prompt in-order memory
		run_job(8, 20);
		run_job(13, 7);
		// same jobs with late, shuffled responses
		shuffle <= 1'b1;
		run_job(8, 20);
		run_job(13, 7);
		// slow consumer
		backpressure <= 1'b1;
		run_job(3, 40);
		backpressure <= 1'b0;

		// job held pending while disabled
		apb_access(1, edge_pkg::reg_ctrl, 32'h0, 0, 0);
		drive_job(0, 10);
		repeat (20) @(posedge clock);
		apb_access(1, edge_pkg::reg_ctrl, 32'h1, 0, 0);
		wait_job_accept();
		wait_job_done();

		assert (edge_rd == edge_wr)
			else begin
				flow_errors++;
				$display("[FAIL] edges popped got 0x%h expected 0x%h", edge_rd, edge_wr);
			end
		apb_access(0, edge_pkg::reg_edge_count, 0, 32'(edge_rd), 0);
		repeat (2) @(posedge clock);

		$display("errors: register %0d, command %0d, edge %0d, flow %0d, timeout %0d",
			reg_errors, cmd_errors, edge_errors, flow_errors, timeouts);
		if (reg_errors + cmd_errors + edge_errors + flow_errors + timeouts == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

// ==== edge_fetch_top.f ====
rtl/edge_pkg.sv
rtl/edge_cfg_regs.sv
rtl/edge_job_control.sv
rtl/cacheline_stream.sv
rtl/edge_fifo.sv
rtl/edge_fetch_top.sv
sim/tb_edge_fetch.sv

// ==== Bender.yml ====
package:
  name: edge_fetch

sources:
  - rtl/edge_pkg.sv
  - rtl/edge_cfg_regs.sv
  - rtl/edge_job_control.sv
  - rtl/cacheline_stream.sv
  - rtl/edge_fifo.sv
  - rtl/edge_fetch_top.sv
  - target: simulation
    files:
      - sim/tb_edge_fetch.sv
